/* design/imagePkg.sv */
package imagePkg;

	// one colour component, unsigned
	typedef logic [7:0] channel_t;

	// fixed point result, 9 integer and 9 fraction bits
	typedef logic signed [17:0] ycc_t;

	// matrix coefficient, 17 fraction bits
	typedef logic signed [17:0] coef_t;

	// wide enough for the sum of three channel by coefficient products
	typedef logic signed [37:0] product_t;

	typedef struct packed {
		channel_t red;
		channel_t green;
		channel_t blue;
	} rgbPixel_t;

	// pixel on the padded stream
	// last marks the final padded position of a frame
	typedef struct packed {
		rgbPixel_t pixel;
		logic      last;
	} paddedBeat_t;

	typedef struct packed {
		ycc_t y;
		ycc_t cb;
		ycc_t cr;
	} yccPixel_t;

	// one matrix row result plus its frame marker
	typedef struct packed {
		ycc_t value;
		logic last;
	} laneResult_t;

	// rows are y, cb, cr; columns multiply r, g, b
	// y  =  0.2988 r + 0.5869 g + 0.1143 b
	// cb = -0.1689 r - 0.3311 g + 0.5000 b
	// cr =  0.5000 r - 0.4189 g - 0.0811 b
	localparam coef_t rgbToYccCoef [3][3] = '{
		'{18'sd39164, 18'sd76926, 18'sd14982},
		'{-18'sd22138, -18'sd43398, 18'sd65536},
		'{18'sd65536, -18'sd54906, -18'sd10630}
	};

	// product stage plus sum stage
	localparam int laneLatency = 2;

	// padder FSM
	typedef enum logic {
		padIdle,
		padStreaming
	} padState_t;

endpackage

/* design/pixelFifo.sv */
module pixelFifo import imagePkg::*; #(
	parameter int fifoDepth = 16
) (
	input  logic      clk,
	input  logic      reset,
	input  rgbPixel_t pushData,
	input  logic      push,
	input  logic      pop,
	output rgbPixel_t headData,
	output logic      empty,
	output logic      full
);

	localparam int ptrWidth = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
	localparam int countWidth = $clog2(fifoDepth + 1);

	// ring storage
	rgbPixel_t mem [fifoDepth];

	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [countWidth-1:0] count;

	// wrap at fifoDepth since the depth need not be a power of two
	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
		if (ptr == ptrWidth'(fifoDepth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// first word fall through
	assign headData = mem[rdPtr];
	assign empty = (count == '0);
	assign full = (count == countWidth'(fifoDepth));

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wrPtr] <= pushData;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (pop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			// occupancy only moves on a one-sided access
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// padder must only pop a visible head
	assert property (@(posedge clk) disable iff (reset) !(pop && empty))
		else $error("pixelFifo: pop while empty");

	// input side must honour inReady
	assert property (@(posedge clk) disable iff (reset) !(push && full))
		else $error("pixelFifo: push while full");

endmodule

/* design/borderPadder.sv */
module borderPadder import imagePkg::*; #(
	parameter int frameWidth = 8,
	parameter int frameHeight = 4,
	parameter int kernelSize = 3
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        startFrame,
	input  rgbPixel_t   fifoData,
	input  logic        fifoEmpty,
	output logic        fifoPop,
	output paddedBeat_t padded,
	output logic        padValid
);

	// zero border on each side, odd kernel assumed
	localparam int border = (kernelSize - 1) / 2;
	localparam int paddedWidth = frameWidth + 2 * border;
	localparam int paddedHeight = frameHeight + 2 * border;
	localparam int colBits = $clog2(paddedWidth + 1);
	localparam int rowBits = $clog2(paddedHeight + 1);

	padState_t state;

	// position inside the padded frame
	logic [colBits-1:0] colCount;
	logic [rowBits-1:0] rowCount;

	logic lastCol;
	logic lastRow;
	logic lastPos;
	logic interior;
	logic advance;

	assign lastCol = (colCount == colBits'(paddedWidth - 1));
	assign lastRow = (rowCount == rowBits'(paddedHeight - 1));
	assign lastPos = lastCol && lastRow;

	// real pixels sit inside the border ring
	assign interior = (rowCount >= rowBits'(border))
		&& (rowCount < rowBits'(border + frameHeight))
		&& (colCount >= colBits'(border))
		&& (colCount < colBits'(border + frameWidth));

	// border never waits, interior waits for a head in the FIFO
	assign advance = (state == padStreaming) && (!interior || !fifoEmpty);

	// consume the head in the cycle it is forwarded
	assign fifoPop = advance && interior;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= padIdle;
			colCount <= '0;
			rowCount <= '0;
			padValid <= 1'b0;
		end else begin
			padValid <= 1'b0;
			case (state)
				padIdle: begin
					// start pulses while streaming are ignored
					if (startFrame) begin
						state <= padStreaming;
						colCount <= '0;
						rowCount <= '0;
					end
				end
				padStreaming: begin
					if (advance) begin
						padValid <= 1'b1;
						if (lastCol) begin
							colCount <= '0;
							rowCount <= rowCount + 1'b1;
						end else begin
							colCount <= colCount + 1'b1;
						end
						// frame finished, back to waiting
						if (lastPos) begin
							rowCount <= '0;
							state <= padIdle;
						end
					end
				end
				default: state <= padIdle;
			endcase
		end
	end

	// beat payload, qualified by padValid
	always_ff @(posedge clk) begin
		if (advance) begin
			padded.pixel <= interior ? fifoData : '0;
			padded.last <= lastPos;
		end
	end

	// every pop happens while streaming and becomes a beat next cycle
	assert property (@(posedge clk) disable iff (reset)
		fifoPop |-> (state == padStreaming) ##1 padValid)
		else $error("borderPadder: pop outside streaming");

endmodule

/* design/colorMatrixLane.sv */
module colorMatrixLane import imagePkg::*; #(
	parameter int laneIndex = 0
) (
	input  logic        clk,
	input  logic        reset,
	input  paddedBeat_t inBeat,
	input  logic        inValid,
	output laneResult_t outResult,
	output logic        outValid
);

	// r, g, b in coefficient column order
	channel_t channels [3];

	// stage one
	product_t prod [3];
	logic valid1;
	logic last1;

	// sum back to 9 fraction bits
	product_t sumShifted;

	assign channels[0] = inBeat.pixel.red;
	assign channels[1] = inBeat.pixel.green;
	assign channels[2] = inBeat.pixel.blue;

	assign sumShifted = (prod[0] + prod[1] + prod[2]) >>> 8;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid1 <= 1'b0;
			outValid <= 1'b0;
		end else begin
			valid1 <= inValid;
			outValid <= valid1;
		end
	end

	always_ff @(posedge clk) begin
		// channels zero extend and coefficients sign extend
		for (int c = 0; c < 3; c++) begin
			prod[c] <= product_t'(channels[c]) * product_t'(rgbToYccCoef[laneIndex][c]);
		end
		last1 <= inBeat.last;
		// keep the low 18 bits of the shifted sum
		outResult.value <= sumShifted[17:0];
		outResult.last <= last1;
	end

endmodule

/* design/yccPacker.sv */
module yccPacker import imagePkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  laneResult_t lanes [3],
	input  logic [2:0]  laneValid,
	output yccPixel_t   yccOut,
	output logic        outValid,
	output logic        frameDone
);

	logic lastFlagsMatch;

	// all three lanes carry the same frame marker
	assign lastFlagsMatch = (lanes[1].last == lanes[0].last)
		&& (lanes[2].last == lanes[0].last);

	// control from lane 0, the others run in lockstep
	always_ff @(posedge clk) begin
		if (reset) begin
			outValid <= 1'b0;
			frameDone <= 1'b0;
		end else begin
			outValid <= laneValid[0];
			// done rides on the final beat of the frame
			frameDone <= laneValid[0] && lanes[0].last;
		end
	end

	always_ff @(posedge clk) begin
		if (laneValid[0]) begin
			yccOut.y <= lanes[0].value;
			yccOut.cb <= lanes[1].value;
			yccOut.cr <= lanes[2].value;
		end
	end

	// lanes fed from one padder beat must agree
	assert property (@(posedge clk) disable iff (reset)
		(laneValid == 3'b000) || ((laneValid == 3'b111) && lastFlagsMatch))
		else $error("yccPacker: lanes out of step");

endmodule

/* design/colorPipeline.sv */
module colorPipeline import imagePkg::*; #(
	parameter int frameWidth = 8,
	parameter int frameHeight = 4,
	parameter int kernelSize = 3,
	parameter int fifoDepth = 16
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      startFrame,
	input  rgbPixel_t pixelIn,
	input  logic      inValid,
	output logic      inReady,
	output yccPixel_t yccOut,
	output logic      outValid,
	output logic      frameDone
);

	// fifo to padder
	rgbPixel_t fifoData;
	logic fifoEmpty;
	logic fifoFull;
	logic fifoPop;
	logic fifoPush;

	// padder to lanes
	paddedBeat_t padded;
	logic padValid;

	// lanes to packer
	laneResult_t laneOut [3];
	logic [2:0] laneValid;

	// only input side has back pressure
	assign inReady = !fifoFull;
	assign fifoPush = inValid && inReady;

	pixelFifo #(
		.fifoDepth(fifoDepth)
	) uFifo (
		.clk(clk),
		.reset(reset),
		.pushData(pixelIn),
		.push(fifoPush),
		.pop(fifoPop),
		.headData(fifoData),
		.empty(fifoEmpty),
		.full(fifoFull)
	);

	borderPadder #(
		.frameWidth(frameWidth),
		.frameHeight(frameHeight),
		.kernelSize(kernelSize)
	) uPadder (
		.clk(clk),
		.reset(reset),
		.startFrame(startFrame),
		.fifoData(fifoData),
		.fifoEmpty(fifoEmpty),
		.fifoPop(fifoPop),
		.padded(padded),
		.padValid(padValid)
	);

	// one lane per matrix row, y cb cr
	for (genvar i = 0; i < 3; i++) begin : gLane
		colorMatrixLane #(
			.laneIndex(i)
		) uLane (
			.clk(clk),
			.reset(reset),
			.inBeat(padded),
			.inValid(padValid),
			.outResult(laneOut[i]),
			.outValid(laneValid[i])
		);
	end

	yccPacker uPacker (
		.clk(clk),
		.reset(reset),
		.lanes(laneOut),
		.laneValid(laneValid),
		.yccOut(yccOut),
		.outValid(outValid),
		.frameDone(frameDone)
	);

endmodule

/* tests/frameModel.svh */
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

// default frame geometry of the pipeline
localparam int modelWidth = 8;
localparam int modelHeight = 4;
localparam int modelBorder = (3 - 1) / 2;
localparam int paddedCols = modelWidth + 2 * modelBorder;
localparam int paddedRows = modelHeight + 2 * modelBorder;
localparam int beatsPerFrame = paddedCols * paddedRows;
localparam int pixelsPerFrame = modelWidth * modelHeight;

// reference RGB to YCbCr matrix, 17 fraction bits
// rows y, cb, cr; columns r, g, b
localparam int coefTable [3][3] = '{
	'{39164, 76926, 14982},
	'{-22138, -43398, 65536},
	'{65536, -54906, -10630}
};

// border ring around the real frame
function automatic bit isBorderBeat(input int beatIndex);
	int row;
	int col;
	row = beatIndex / paddedCols;
	col = beatIndex % paddedCols;
	return (row < modelBorder) || (row >= modelBorder + modelHeight)
		|| (col < modelBorder) || (col >= modelBorder + modelWidth);
endfunction

// one matrix row, drop 8 fraction bits and keep 18 bits
function automatic ycc_t matrixRow(input rgbPixel_t pix, input int row);
	longint acc;
	acc = longint'(pix.red) * coefTable[row][0]
		+ longint'(pix.green) * coefTable[row][1]
		+ longint'(pix.blue) * coefTable[row][2];
	return ycc_t'(acc >>> 8);
endfunction

function automatic yccPixel_t expectedYcc(input rgbPixel_t pix);
	yccPixel_t res;
	res.y = matrixRow(pix, 0);
	res.cb = matrixRow(pix, 1);
	res.cr = matrixRow(pix, 2);
	return res;
endfunction

`endif

/* tests/colorPipelineTb.sv */
module colorPipelineTb import imagePkg::*; ();

	`include "frameModel.svh"

	// three frames of beats that may each stall 4 cycles plus reset and burst slack
	localparam int timeoutCycles = 3 * beatsPerFrame * 4 + 200;

	logic clk;
	logic reset;
	logic startFrame;
	rgbPixel_t pixelIn;
	logic inValid;
	logic inReady;
	yccPixel_t yccOut;
	logic outValid;
	logic frameDone;

	integer seed = 32'h2d554748;
	rgbPixel_t sentQ [$];
	int beatCount;
	int pixIdx;
	int totalBeats;
	int cycleCount;
	int gapCycles;
	int valueErrors;
	int protocolErrors;
	logic started;
	logic sawBackPressure;
	yccPixel_t expectedBeat;
	logic pixelAvailable;

	colorPipeline uut (
		.clk(clk),
		.reset(reset),
		.startFrame(startFrame),
		.pixelIn(pixelIn),
		.inValid(inValid),
		.inReady(inReady),
		.yccOut(yccOut),
		.outValid(outValid),
		.frameDone(frameDone)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// model output for the beat that is due next
	always_comb begin
		pixelAvailable = isBorderBeat(beatCount) || (pixIdx < sentQ.size());
		expectedBeat = '0;
		if (!isBorderBeat(beatCount) && pixIdx < sentQ.size()) begin
			expectedBeat = expectedYcc(sentQ[pixIdx]);
		end
	end

	// position in the padded frame and in the sent pixel stream
	always @(posedge clk) begin
		if (reset) begin
			beatCount <= 0;
			pixIdx <= 0;
			totalBeats <= 0;
			gapCycles <= 0;
		end else if (outValid) begin
			totalBeats <= totalBeats + 1;
			if (!isBorderBeat(beatCount)) begin
				pixIdx <= pixIdx + 1;
			end
			beatCount <= (beatCount == beatsPerFrame - 1) ? 0 : beatCount + 1;
		end else if (beatCount != 0) begin
			// stall inside a frame
			gapCycles <= gapCycles + 1;
		end
	end

	// hard stop
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Timeout after %0d cycles, frame never completed", cycleCount);
			$display("Testbench failed");
			$finish;
		end
	end

	// zero on the border and the converted pixel inside
	checkValue: assert property (@(posedge clk) disable iff (reset)
		outValid && pixelAvailable |-> yccOut == expectedBeat)
		else begin
			valueErrors++;
			$display("CHECK FAILED yccOut beat %0d: got %h expected %h",
				$sampled(beatCount), $sampled(yccOut), $sampled(expectedBeat));
		end

	checkSource: assert property (@(posedge clk) disable iff (reset)
		outValid |-> pixelAvailable)
		else begin
			protocolErrors++;
			$display("interior beat %0d came out before its pixel was sent",
				$sampled(beatCount));
		end

	// done only with the final padded beat
	checkDone: assert property (@(posedge clk) disable iff (reset)
		outValid |-> frameDone == (beatCount == beatsPerFrame - 1))
		else begin
			valueErrors++;
			$display("CHECK FAILED frameDone beat %0d: got %h expected %h",
				$sampled(beatCount), $sampled(frameDone),
				$sampled(beatCount) == beatsPerFrame - 1);
		end

	checkDoneValid: assert property (@(posedge clk) disable iff (reset)
		frameDone |-> outValid)
		else begin
			protocolErrors++;
			$display("frameDone raised without outValid");
		end

	checkIdle: assert property (@(posedge clk) disable iff (reset)
		!started |-> !outValid && !frameDone)
		else begin
			protocolErrors++;
			$display("output activity before the first startFrame");
		end

	// padded beat reaches the output after the lanes and the packer register
	checkLatency: assert property (@(posedge clk) disable iff (reset)
		uut.padValid |-> ##(laneLatency + 1) outValid)
		else begin
			protocolErrors++;
			$display("outValid missing %0d cycles after a padded beat",
				laneLatency + 1);
		end

	// holds each pixel until accepted and then waits a random gap
	task automatic sendPixels(input int count, input int maxGap);
		logic [31:0] randWord;
		rgbPixel_t pix;
		int gap;
		for (int i = 0; i < count; i++) begin
			randWord = $random(seed);
			pix = randWord[23:0];
			pixelIn = pix;
			inValid = 1'b1;
			@(posedge clk);
			while (!inReady) begin
				sawBackPressure = 1'b1;
				@(posedge clk);
			end
			sentQ.push_back(pix);
			#1;
			inValid = 1'b0;
			gap = (maxGap > 0) ? $unsigned($random(seed)) % (maxGap + 1) : 0;
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
		end
	endtask

	// called one unit after a rising edge
	task automatic pulseStart();
		startFrame = 1'b1;
		started = 1'b1;
		@(posedge clk);
		#1;
		startFrame = 1'b0;
	endtask

	task automatic finishFrame(input int frameNumber);
		@(posedge clk);
		while (!frameDone) begin
			@(posedge clk);
		end
		#1;
		assert (pixIdx == frameNumber * pixelsPerFrame
			&& totalBeats == frameNumber * beatsPerFrame)
		else begin
			protocolErrors++;
			$display("frame %0d ended after %0d beats and %0d pixels in total",
				frameNumber, totalBeats, pixIdx);
		end
	endtask

	initial begin
		reset = 1'b1;
		startFrame = 1'b0;
		pixelIn = '0;
		inValid = 1'b0;
		started = 1'b0;
		sawBackPressure = 1'b0;
		valueErrors = 0;
		protocolErrors = 0;
		cycleCount = 0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		// outputs stay quiet while idle
		repeat (5) begin
			@(posedge clk);
			#1;
		end
		assert (inReady)
		else begin
			protocolErrors++;
			$display("inReady low while idle after reset");
		end
		// first frame bursts past the FIFO depth and starts once it fills
		fork
			sendPixels(pixelsPerFrame, 0);
			begin
				wait (sawBackPressure);
				#1;
				pulseStart();
			end
		join
		finishFrame(1);
		// second frame starts first and trickles its pixels in
		pulseStart();
		sendPixels(pixelsPerFrame, 5);
		finishFrame(2);
		assert (gapCycles > 0)
		else begin
			protocolErrors++;
			$display("outValid never dropped while the FIFO ran empty");
		end
		repeat (4) @(posedge clk);
		$display("value errors %0d, protocol errors %0d, beats %0d, pixels %0d",
			valueErrors, protocolErrors, totalBeats, sentQ.size());
		if (valueErrors == 0 && protocolErrors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* project.f */
+incdir+tests
design/imagePkg.sv
design/pixelFifo.sv
design/borderPadder.sv
design/colorMatrixLane.sv
design/yccPacker.sv
design/colorPipeline.sv
tests/colorPipelineTb.sv
